//--- logic/axi_read_engine.sv
module axi_read_engine
  (input clk_i
   , input rst_i

   , input mem_bridge_pkg::dma_pkt_s dma_pkt_i
   , input dma_pkt_v_i
   , output logic dma_pkt_yumi_o

   , output mem_bridge_pkg::axi_aw_s ar_o
   , output logic arvalid_o
   , input arready_i

   , input mem_bridge_pkg::axi_r_s r_i
   , input rvalid_i
   , output logic rready_o

   , output logic [mem_bridge_pkg::axi_data_width_c-1:0] dma_data_o
   , output logic dma_data_v_o
   , input dma_data_ready_i
  );

  localparam logic [1:0] idle_s = 2'd0;
  localparam logic [1:0] ar_s   = 2'd1;
  localparam logic [1:0] r_s    = 2'd2;

  logic [1:0]                                  state_r;
  logic [mem_bridge_pkg::dma_addr_width_c-1:0] addr_r;

  assign dma_pkt_yumi_o = (state_r == idle_s) & dma_pkt_v_i & ~dma_pkt_i.write_not_read;

  assign ar_o      = mem_bridge_pkg::block_burst(addr_r);
  assign arvalid_o = (state_r == ar_s);

  // r beats pass straight to the reply side
  assign dma_data_o   = r_i.data;
  assign dma_data_v_o = (state_r == r_s) & rvalid_i;
  assign rready_o     = (state_r == r_s) & dma_data_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= idle_s;
    end else begin
      case (state_r)
        idle_s: begin
          if (dma_pkt_yumi_o) state_r <= ar_s;
        end
        ar_s: begin
          if (arready_i) state_r <= r_s;
        end
        default: begin
          if (rvalid_i && rready_o && r_i.last) state_r <= idle_s;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) begin
      addr_r <= dma_pkt_i.addr;
    end
  end

endmodule

//--- logic/axi_write_engine.sv
module axi_write_engine
  (input clk_i
   , input rst_i

   , input mem_bridge_pkg::dma_pkt_s dma_pkt_i
   , input dma_pkt_v_i
   , output logic dma_pkt_yumi_o

   , input [mem_bridge_pkg::axi_data_width_c-1:0] dma_data_i
   , input dma_data_v_i
   , output logic dma_data_yumi_o

   , output mem_bridge_pkg::axi_aw_s aw_o
   , output logic awvalid_o
   , input awready_i

   , output mem_bridge_pkg::axi_w_s w_o
   , output logic wvalid_o
   , input wready_i

   , input mem_bridge_pkg::axi_r_s b_i
   , input bvalid_i
   , output logic bready_o
  );

  localparam int cnt_width_lp = $clog2(mem_bridge_pkg::burst_len_c);

  localparam logic [1:0] idle_s = 2'd0;
  localparam logic [1:0] aw_s   = 2'd1;
  localparam logic [1:0] w_s    = 2'd2;
  localparam logic [1:0] b_s    = 2'd3;

  logic [1:0]                                  state_r;
  logic [cnt_width_lp-1:0]                     beat_r;
  logic [mem_bridge_pkg::dma_addr_width_c-1:0] addr_r;

  assign dma_pkt_yumi_o = (state_r == idle_s) & dma_pkt_v_i & dma_pkt_i.write_not_read;

  assign aw_o      = mem_bridge_pkg::block_burst(addr_r);
  assign awvalid_o = (state_r == aw_s);

  assign w_o.data = dma_data_i;
  assign w_o.strb = '1;
  assign w_o.last = (beat_r == cnt_width_lp'(mem_bridge_pkg::burst_len_c - 1));
  assign wvalid_o = (state_r == w_s) & dma_data_v_i;
  assign dma_data_yumi_o = wvalid_o & wready_i;

  // response is only waited on, slave errors are not retried
  assign bready_o = (state_r == b_s);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= idle_s;
      beat_r  <= '0;
    end else begin
      case (state_r)
        idle_s: begin
          if (dma_pkt_yumi_o) state_r <= aw_s;
        end
        aw_s: begin
          if (awready_i) state_r <= w_s;
        end
        w_s: begin
          if (dma_data_yumi_o) begin
            beat_r <= beat_r + cnt_width_lp'(1);
            if (w_o.last) state_r <= b_s;
          end
        end
        default: begin
          if (bvalid_i) state_r <= idle_s;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) begin
      addr_r <= dma_pkt_i.addr;
    end
  end

endmodule

//--- logic/mem_bridge_pkg.sv
package mem_bridge_pkg;

  // wormhole link
  localparam int flit_width_c = 32;
  localparam int cord_width_c = 8;
  localparam int len_width_c  = 4;
  localparam int cid_width_c  = 2;

  // dma and axi side
  localparam int dma_addr_width_c = 28;
  localparam int axi_addr_width_c = 32;
  localparam int axi_data_width_c = 32;
  localparam int axi_id_width_c   = 4;
  localparam int burst_len_c      = 4;

  // ruche factor of 2
  localparam int lg_ruche_factor_c = 1;

  localparam logic [1:0] axi_burst_incr_c = 2'b01;

  typedef struct packed {
    logic [cord_width_c-1:0] dest_cord;
    logic [len_width_c-1:0]  len;
    logic [cid_width_c-1:0]  cid;
    logic [cord_width_c-1:0] src_cord;
    logic                    write_not_read;
    logic [8:0]              padding;
  } wh_header_s;

  // same word seen as header or as payload
  typedef union packed {
    wh_header_s              header;
    logic [flit_width_c-1:0] data;
  } wh_flit_u;

  typedef struct packed {
    logic     valid;
    wh_flit_u data;
    logic     ready_and_rev;
  } wh_link_s;

  typedef struct packed {
    logic                        write_not_read;
    logic [dma_addr_width_c-1:0] addr;
  } dma_pkt_s;

  // shared by aw and ar
  typedef struct packed {
    logic [axi_id_width_c-1:0]   id;
    logic [axi_addr_width_c-1:0] addr;
    logic [7:0]                  len;
    logic [2:0]                  size;
    logic [1:0]                  burst;
  } axi_aw_s;

  typedef struct packed {
    logic [axi_data_width_c-1:0]     data;
    logic [axi_data_width_c/8-1:0]   strb;
    logic                            last;
  } axi_w_s;

  // also carries b, resp only
  typedef struct packed {
    logic [axi_data_width_c-1:0] data;
    logic [1:0]                  resp;
    logic                        last;
  } axi_r_s;

  // one cache block as a single incr burst
  function automatic axi_aw_s block_burst(input logic [dma_addr_width_c-1:0] addr);
    axi_aw_s aw;
    aw.id    = '0;
    aw.addr  = axi_addr_width_c'(addr);
    aw.len   = 8'(burst_len_c - 1);
    aw.size  = 3'($clog2(axi_data_width_c / 8));
    aw.burst = axi_burst_incr_c;
    return aw;
  endfunction

endpackage

//--- logic/mem_bridge_top.sv
module mem_bridge_top
  #(parameter int tag_cycles_p = 8
    , parameter int reset_depth_p = 3
    , parameter int ruche_lane_p = 1
    , parameter int lg_mem_size_p = 16
    , parameter int lg_num_vcaches_p = 2
  )
  (input clk_i
   , input rst_n_i
   , output logic tag_done_o

   , input mem_bridge_pkg::wh_link_s wh_link_i
   , output mem_bridge_pkg::wh_link_s wh_link_o

   , output mem_bridge_pkg::axi_aw_s aw_o
   , output logic awvalid_o
   , input awready_i

   , output mem_bridge_pkg::axi_w_s w_o
   , output logic wvalid_o
   , input wready_i

   , input mem_bridge_pkg::axi_r_s b_i
   , input bvalid_i
   , output logic bready_o

   , output mem_bridge_pkg::axi_aw_s ar_o
   , output logic arvalid_o
   , input arready_i

   , input mem_bridge_pkg::axi_r_s r_i
   , input rvalid_i
   , output logic rready_o
  );

  logic core_rst_lo;

  mem_bridge_pkg::dma_pkt_s dma_pkt_lo;
  logic dma_pkt_v_lo;
  logic wr_pkt_yumi_li;
  logic rd_pkt_yumi_li;

  logic [mem_bridge_pkg::axi_data_width_c-1:0] wr_data_lo;
  logic wr_data_v_lo;
  logic wr_data_yumi_li;

  logic [mem_bridge_pkg::axi_data_width_c-1:0] rd_data_lo;
  logic rd_data_v_lo;
  logic rd_data_ready_li;

  logic [mem_bridge_pkg::cord_width_c-1:0] reply_cord_lo;
  logic reply_v_lo;
  logic rx_ready_lo;
  mem_bridge_pkg::wh_link_s tx_link_lo;

  reset_sequencer #(
    .tag_cycles_p(tag_cycles_p)
    ,.reset_depth_p(reset_depth_p)
  ) seq (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_done_o(tag_done_o)
    ,.core_rst_o(core_rst_lo)
  );

  wh_dma_rx #(
    .ruche_lane_p(ruche_lane_p)
    ,.lg_mem_size_p(lg_mem_size_p)
    ,.lg_num_vcaches_p(lg_num_vcaches_p)
  ) rx (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.wh_in_i(wh_link_i)
    ,.wh_ready_o(rx_ready_lo)
    ,.dma_pkt_o(dma_pkt_lo)
    ,.dma_pkt_v_o(dma_pkt_v_lo)
    ,.dma_pkt_yumi_i(wr_pkt_yumi_li | rd_pkt_yumi_li)
    ,.dma_data_o(wr_data_lo)
    ,.dma_data_v_o(wr_data_v_lo)
    ,.dma_data_yumi_i(wr_data_yumi_li)
    ,.reply_cord_o(reply_cord_lo)
    ,.reply_v_o(reply_v_lo)
  );

  wh_dma_tx #(
    .ruche_lane_p(ruche_lane_p)
  ) tx (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.reply_cord_i(reply_cord_lo)
    ,.reply_v_i(reply_v_lo)
    ,.dma_data_i(rd_data_lo)
    ,.dma_data_v_i(rd_data_v_lo)
    ,.dma_data_ready_o(rd_data_ready_li)
    ,.wh_out_o(tx_link_lo)
    ,.wh_ready_i(wh_link_i.ready_and_rev)
  );

  // forward half from tx, reverse ready from rx
  assign wh_link_o.valid         = tx_link_lo.valid;
  assign wh_link_o.data          = tx_link_lo.data;
  assign wh_link_o.ready_and_rev = rx_ready_lo;

  axi_write_engine wr_eng (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.dma_pkt_i(dma_pkt_lo)
    ,.dma_pkt_v_i(dma_pkt_v_lo)
    ,.dma_pkt_yumi_o(wr_pkt_yumi_li)
    ,.dma_data_i(wr_data_lo)
    ,.dma_data_v_i(wr_data_v_lo)
    ,.dma_data_yumi_o(wr_data_yumi_li)
    ,.aw_o(aw_o)
    ,.awvalid_o(awvalid_o)
    ,.awready_i(awready_i)
    ,.w_o(w_o)
    ,.wvalid_o(wvalid_o)
    ,.wready_i(wready_i)
    ,.b_i(b_i)
    ,.bvalid_i(bvalid_i)
    ,.bready_o(bready_o)
  );

  axi_read_engine rd_eng (
    .clk_i(clk_i)
    ,.rst_i(core_rst_lo)
    ,.dma_pkt_i(dma_pkt_lo)
    ,.dma_pkt_v_i(dma_pkt_v_lo)
    ,.dma_pkt_yumi_o(rd_pkt_yumi_li)
    ,.ar_o(ar_o)
    ,.arvalid_o(arvalid_o)
    ,.arready_i(arready_i)
    ,.r_i(r_i)
    ,.rvalid_i(rvalid_i)
    ,.rready_o(rready_o)
    ,.dma_data_o(rd_data_lo)
    ,.dma_data_v_o(rd_data_v_lo)
    ,.dma_data_ready_i(rd_data_ready_li)
  );

endmodule

//--- logic/reset_sequencer.sv
module reset_sequencer
  #(parameter int tag_cycles_p = 8
    , parameter int reset_depth_p = 3
  )
  (input clk_i
   , input rst_n_i
   , output logic tag_done_o
   , output logic core_rst_o
  );

  localparam int cnt_width_lp = $clog2(tag_cycles_p + 1);

  logic [cnt_width_lp-1:0]  tag_cnt_r;
  logic [reset_depth_p-1:0] rst_chain_r;

  // tag programming window
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tag_cnt_r  <= '0;
      tag_done_o <= 1'b0;
    end else begin
      if (tag_cnt_r != cnt_width_lp'(tag_cycles_p)) begin
        tag_cnt_r <= tag_cnt_r + cnt_width_lp'(1);
      end
      tag_done_o <= (tag_cnt_r == cnt_width_lp'(tag_cycles_p));
    end
  end

  // core reset trails tag done
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_chain_r <= '1;
    end else begin
      rst_chain_r <= (rst_chain_r << 1) | reset_depth_p'(!tag_done_o);
    end
  end

  assign core_rst_o = rst_chain_r[reset_depth_p-1];

endmodule

//--- logic/wh_dma_rx.sv
module wh_dma_rx
  #(parameter int ruche_lane_p = 1
    , parameter int lg_mem_size_p = 16
    , parameter int lg_num_vcaches_p = 2
  )
  (input clk_i
   , input rst_i

   , input mem_bridge_pkg::wh_link_s wh_in_i
   , output logic wh_ready_o

   , output mem_bridge_pkg::dma_pkt_s dma_pkt_o
   , output logic dma_pkt_v_o
   , input dma_pkt_yumi_i

   , output logic [mem_bridge_pkg::axi_data_width_c-1:0] dma_data_o
   , output logic dma_data_v_o
   , input dma_data_yumi_i

   , output logic [mem_bridge_pkg::cord_width_c-1:0] reply_cord_o
   , output logic reply_v_o
  );

  localparam bit invert_lp = (ruche_lane_p % 2) == 1;
  localparam int pad_width_lp =
    mem_bridge_pkg::dma_addr_width_c - lg_num_vcaches_p - lg_mem_size_p;
  localparam int cnt_width_lp = $clog2(mem_bridge_pkg::burst_len_c);

  localparam logic [2:0] idle_s = 3'd0;
  localparam logic [2:0] hdr_s  = 3'd1;
  localparam logic [2:0] addr_s = 3'd2;
  localparam logic [2:0] pkt_s  = 3'd3;
  localparam logic [2:0] data_s = 3'd4;

  logic [2:0]                              state_r;
  logic [cnt_width_lp-1:0]                 beat_r;
  logic [mem_bridge_pkg::cord_width_c-1:0] src_cord_r;
  mem_bridge_pkg::dma_pkt_s                pkt_r;
  mem_bridge_pkg::wh_flit_u                flit;
  logic                                    flit_fire;

  // odd lanes arrive inverted
  assign flit.data = wh_in_i.data.data ^ {mem_bridge_pkg::flit_width_c{invert_lp}};

  assign wh_ready_o = (state_r == hdr_s) | (state_r == addr_s)
                    | ((state_r == data_s) & dma_data_yumi_i);
  assign flit_fire  = wh_in_i.valid & wh_ready_o;

  assign dma_pkt_o    = pkt_r;
  assign dma_pkt_v_o  = (state_r == pkt_s);
  assign dma_data_o   = flit.data;
  assign dma_data_v_o = (state_r == data_s) & wh_in_i.valid;

  assign reply_cord_o = src_cord_r;
  assign reply_v_o    = (state_r == pkt_s) & dma_pkt_yumi_i & ~pkt_r.write_not_read;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= idle_s;
      beat_r  <= '0;
    end else begin
      case (state_r)
        idle_s: begin
          state_r <= hdr_s;
        end
        hdr_s: begin
          if (flit_fire) state_r <= addr_s;
        end
        addr_s: begin
          if (flit_fire) state_r <= pkt_s;
        end
        pkt_s: begin
          if (dma_pkt_yumi_i) state_r <= pkt_r.write_not_read ? data_s : hdr_s;
        end
        data_s: begin
          if (flit_fire) begin
            beat_r <= beat_r + cnt_width_lp'(1);
            if (beat_r == cnt_width_lp'(mem_bridge_pkg::burst_len_c - 1)) begin
              state_r <= hdr_s;
            end
          end
        end
        default: begin
          state_r <= idle_s;
        end
      endcase
    end
  end

  // header fields, then remapped address
  always_ff @(posedge clk_i) begin
    if (flit_fire && state_r == hdr_s) begin
      src_cord_r           <= flit.header.src_cord;
      pkt_r.write_not_read <= flit.header.write_not_read;
    end
    if (flit_fire && state_r == addr_s) begin
      pkt_r.addr <= {{pad_width_lp{1'b0}},
                     src_cord_r[mem_bridge_pkg::lg_ruche_factor_c +: lg_num_vcaches_p],
                     flit.data[lg_mem_size_p-1:0]};
    end
  end

endmodule

//--- logic/wh_dma_tx.sv
module wh_dma_tx
  #(parameter int ruche_lane_p = 1)
  (input clk_i
   , input rst_i

   , input [mem_bridge_pkg::cord_width_c-1:0] reply_cord_i
   , input reply_v_i

   , input [mem_bridge_pkg::axi_data_width_c-1:0] dma_data_i
   , input dma_data_v_i
   , output logic dma_data_ready_o

   , output mem_bridge_pkg::wh_link_s wh_out_o
   , input wh_ready_i
  );

  localparam bit invert_lp = (ruche_lane_p % 2) == 1;
  localparam int cnt_width_lp = $clog2(mem_bridge_pkg::burst_len_c);

  localparam logic [1:0] idle_s = 2'd0;
  localparam logic [1:0] hdr_s  = 2'd1;
  localparam logic [1:0] data_s = 2'd2;

  logic [1:0]                              state_r;
  logic [cnt_width_lp-1:0]                 beat_r;
  logic [mem_bridge_pkg::cord_width_c-1:0] cord_r;
  mem_bridge_pkg::wh_flit_u                flit;
  logic                                    flit_fire;

  always_comb begin
    if (state_r == hdr_s) begin
      flit.header = '{dest_cord: cord_r,
                      len: mem_bridge_pkg::len_width_c'(mem_bridge_pkg::burst_len_c),
                      default: '0};
    end else begin
      flit.data = dma_data_i;
    end
  end

  assign wh_out_o.valid     = (state_r == hdr_s) | ((state_r == data_s) & dma_data_v_i);
  assign wh_out_o.data.data = flit.data ^ {mem_bridge_pkg::flit_width_c{invert_lp}};
  // reverse ready of this link comes from the rx side
  assign wh_out_o.ready_and_rev = 1'b0;

  assign flit_fire        = wh_out_o.valid & wh_ready_i;
  assign dma_data_ready_o = (state_r == data_s) & wh_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= idle_s;
      beat_r  <= '0;
    end else begin
      case (state_r)
        idle_s: begin
          // first read beat waiting
          if (dma_data_v_i) state_r <= hdr_s;
        end
        hdr_s: begin
          if (flit_fire) state_r <= data_s;
        end
        default: begin
          if (flit_fire) begin
            beat_r <= beat_r + cnt_width_lp'(1);
            if (beat_r == cnt_width_lp'(mem_bridge_pkg::burst_len_c - 1)) begin
              state_r <= idle_s;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reply_v_i) begin
      cord_r <= reply_cord_i;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module mem_bridge_tb \
  -f sources.f

./obj_dir/Vmem_bridge_tb

//--- sources.f
logic/mem_bridge_pkg.sv
logic/reset_sequencer.sv
logic/wh_dma_rx.sv
logic/wh_dma_tx.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/mem_bridge_top.sv
testbench/mem_bridge_chk.sv
testbench/mem_bridge_tb.sv

//--- testbench/mem_bridge_chk.sv
module mem_bridge_chk
  (input clk_i
   , input rst_n_i
   , input mem_bridge_pkg::axi_aw_s aw_i
   , input awvalid_i
   , input awready_i
   , input mem_bridge_pkg::axi_aw_s ar_i
   , input arvalid_i
   , input arready_i
   , input mem_bridge_pkg::axi_w_s w_i
   , input wvalid_i
   , input wready_i
  );
  timeunit 1ns;
  timeprecision 1ps;

  logic       aw_done_r;
  logic [1:0] beat_r;

  // burst open from aw handshake to last w beat
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_done_r <= 1'b0;
      beat_r    <= '0;
    end else begin
      if (awvalid_i && awready_i) aw_done_r <= 1'b1;
      if (wvalid_i && wready_i) begin
        beat_r <= w_i.last ? 2'd0 : beat_r + 2'd1;
        if (w_i.last) aw_done_r <= 1'b0;
      end
    end
  end

  aw_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
    else $error("awvalid or aw fields changed before awready");

  ar_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
    else $error("arvalid or ar fields changed before arready");

  w_after_aw_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i |-> aw_done_r)
    else $error("wvalid raised before the aw handshake");

  wlast_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_i && wready_i |-> (w_i.last == (beat_r == 2'd3)))
    else $error("wlast not on the fourth beat");

endmodule

bind mem_bridge_top mem_bridge_chk i_chk (
  .clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.aw_i(aw_o)
  ,.awvalid_i(awvalid_o)
  ,.awready_i(awready_i)
  ,.ar_i(ar_o)
  ,.arvalid_i(arvalid_o)
  ,.arready_i(arready_i)
  ,.w_i(w_o)
  ,.wvalid_i(wvalid_o)
  ,.wready_i(wready_i)
);

//--- testbench/mem_bridge_golden.txt
// kind src_cord address data0 data1 data2 data3, all hex
// kind 1 is a write and 0 a read, data is written or returned on R
1 10 0ABC1230 11111111 22222222 33333333 44444444
0 10 0ABC1230 A5A5A5A5 5A5A5A5A DEADBEEF 01234567
1 13 0001F000 CAFEF00D 0BADC0DE 13579BDF 2468ACE0
0 13 0001F000 FFFFFFFF 00000000 80000001 7FFFFFFE
1 25 07FF8040 10203040 50607080 90A0B0C0 D0E0F000
0 25 07FF8040 89ABCDEF FEDCBA98 76543210 0F1E2D3C
1 07 0123FFF0 AAAA5555 5555AAAA 12121212 34343434
0 07 0123FFF0 C3C3C3C3 3C3C3C3C 00FF00FF FF00FF00
0 34 00004560 600DF00D B16B00B5 1EE7C0DE 0DDBA115
1 3A 0F00A0C0 ABCDEF01 23456789 9876FEDC 55AA55AA

//--- testbench/mem_bridge_tb.sv
module mem_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int tag_cycles_c     = 8;
  localparam int reset_depth_c    = 3;
  localparam int ruche_lane_c     = 1;
  localparam int lg_mem_size_c    = 16;
  localparam int lg_num_vcaches_c = 2;
  localparam int num_txn_c        = 10;
  localparam int txn_words_c      = 7;
  localparam int timeout_c        = 200;

  logic clk_i;
  logic rst_n_i;
  logic tag_done_o;

  logic                     in_valid;
  mem_bridge_pkg::wh_flit_u in_flit;
  logic                     reply_ready;
  mem_bridge_pkg::wh_link_s wh_link_i;
  mem_bridge_pkg::wh_link_s wh_link_o;

  mem_bridge_pkg::axi_aw_s aw_o;
  logic                    awvalid_o;
  logic                    awready_i;
  mem_bridge_pkg::axi_w_s  w_o;
  logic                    wvalid_o;
  logic                    wready_i;
  mem_bridge_pkg::axi_r_s  b_i;
  logic                    bvalid_i;
  logic                    bready_o;
  mem_bridge_pkg::axi_aw_s ar_o;
  logic                    arvalid_o;
  logic                    arready_i;
  mem_bridge_pkg::axi_r_s  r_i;
  logic                    rvalid_i;
  logic                    rready_o;

  logic [31:0] golden_q [0:num_txn_c*txn_words_c-1];
  integer      seed;

  assign wh_link_i = '{valid: in_valid, data: in_flit, ready_and_rev: reply_ready};

  mem_bridge_top #(
    .tag_cycles_p(tag_cycles_c)
    ,.reset_depth_p(reset_depth_c)
    ,.ruche_lane_p(ruche_lane_c)
    ,.lg_mem_size_p(lg_mem_size_c)
    ,.lg_num_vcaches_p(lg_num_vcaches_c)
  ) i_dut (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_done_o(tag_done_o)
    ,.wh_link_i(wh_link_i)
    ,.wh_link_o(wh_link_o)
    ,.aw_o(aw_o)
    ,.awvalid_o(awvalid_o)
    ,.awready_i(awready_i)
    ,.w_o(w_o)
    ,.wvalid_o(wvalid_o)
    ,.wready_i(wready_i)
    ,.b_i(b_i)
    ,.bvalid_i(bvalid_i)
    ,.bready_o(bready_o)
    ,.ar_o(ar_o)
    ,.arvalid_o(arvalid_o)
    ,.arready_i(arready_i)
    ,.r_i(r_i)
    ,.rvalid_i(rvalid_i)
    ,.rready_o(rready_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_aw(input string name, input mem_bridge_pkg::axi_aw_s got,
                          input mem_bridge_pkg::axi_aw_s exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_w(input string name, input mem_bridge_pkg::axi_w_s got,
                         input mem_bridge_pkg::axi_w_s exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic check_flit(input string name, input mem_bridge_pkg::wh_flit_u got,
                            input mem_bridge_pkg::wh_flit_u exp);
    if (got.data !== exp.data) begin
      stop_on_error($sformatf("** Error: %s expected %h got %h", name, exp.data, got.data));
    end
  endtask

  // mostly ready, sometimes stalled
  function automatic logic coin_flip();
    return ($random(seed) & 3) != 0;
  endfunction

  // lane polarity as seen on the wire
  function automatic mem_bridge_pkg::wh_flit_u wire_flit(input mem_bridge_pkg::wh_flit_u f);
    mem_bridge_pkg::wh_flit_u w;
    w.data = f.data ^ {32{ruche_lane_c % 2 == 1}};
    return w;
  endfunction

  function automatic logic [31:0] remap_addr(input logic [7:0] src, input logic [27:0] addr);
    logic [31:0] a;
    a = 32'(src[1 +: lg_num_vcaches_c]) << lg_mem_size_c;
    a = a | (32'(addr) & ((32'd1 << lg_mem_size_c) - 32'd1));
    return a;
  endfunction

  task automatic check_reset_sequence();
    int cycles;
    int rise;
    cycles = 0;
    rise = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      @(negedge clk_i);
      if (tag_done_o && rise == 0) rise = cycles;
      if (i_dut.core_rst_lo && (awvalid_o | arvalid_o | wvalid_o | bready_o | rready_o
                                | wh_link_o.valid | wh_link_o.ready_and_rev)) begin
        stop_on_error("bridge drove a valid or ready while the core reset was held");
      end
      if (cycles > timeout_c) stop_on_error("timeout waiting for core reset release");
    end while (i_dut.core_rst_lo);
    // cycle 1 is the first edge with reset released
    if (rise != tag_cycles_c + 1) begin
      stop_on_error($sformatf("** Error: tag_done_o rise cycle expected %h got %h",
                              tag_cycles_c + 1, rise));
    end
  endtask

  task automatic send_flit(input mem_bridge_pkg::wh_flit_u f);
    int waited;
    waited = 0;
    @(posedge clk_i);
    in_valid <= 1'b1;
    in_flit  <= wire_flit(f);
    @(negedge clk_i);
    while (!wh_link_o.ready_and_rev) begin
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for the bridge to take a flit");
      @(negedge clk_i);
    end
  endtask

  task automatic send_packet(input mem_bridge_pkg::wh_flit_u hdr, input logic [27:0] addr,
                             input int base, input logic is_write);
    mem_bridge_pkg::wh_flit_u f;
    send_flit(hdr);
    f.data = {4'h0, addr};
    send_flit(f);
    if (is_write) begin
      for (int i = 0; i < 4; i++) begin
        f.data = golden_q[base+3+i];
        send_flit(f);
      end
    end
    @(posedge clk_i);
    in_valid <= 1'b0;
  endtask

  task automatic serve_addr(input logic is_write, input mem_bridge_pkg::axi_aw_s exp);
    int waited;
    logic done;
    waited = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (is_write) awready_i <= coin_flip();
      else arready_i <= coin_flip();
      @(negedge clk_i);
      if (is_write && awvalid_o && awready_i) begin
        check_aw("aw_o", aw_o, exp);
        done = 1'b1;
      end else if (!is_write && arvalid_o && arready_i) begin
        check_aw("ar_o", ar_o, exp);
        done = 1'b1;
      end
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for an address handshake");
    end
    @(posedge clk_i);
    awready_i <= 1'b0;
    arready_i <= 1'b0;
  endtask

  task automatic serve_write(input mem_bridge_pkg::axi_aw_s exp, input int base);
    int beat;
    int waited;
    mem_bridge_pkg::axi_w_s exp_w;
    serve_addr(1'b1, exp);
    beat = 0;
    waited = 0;
    while (beat < 4) begin
      @(posedge clk_i);
      wready_i <= coin_flip();
      @(negedge clk_i);
      if (wvalid_o && wready_i) begin
        exp_w = '{data: golden_q[base+3+beat], strb: 4'hf, last: beat == 3};
        check_w("w_o", w_o, exp_w);
        beat++;
      end
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for write data beats");
    end
    @(posedge clk_i);
    wready_i <= 1'b0;
    bvalid_i <= 1'b1;
    b_i      <= '0;
    waited = 0;
    @(negedge clk_i);
    while (!bready_o) begin
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for the write response ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    bvalid_i <= 1'b0;
  endtask

  task automatic serve_read(input mem_bridge_pkg::axi_aw_s exp, input int base);
    int beat;
    int waited;
    logic holding;
    serve_addr(1'b0, exp);
    beat = 0;
    waited = 0;
    holding = 1'b0;
    while (beat < 4) begin
      @(posedge clk_i);
      // a presented beat stays until rready
      if (!holding) begin
        rvalid_i <= coin_flip();
        r_i      <= '{data: golden_q[base+3+beat], resp: 2'b00, last: beat == 3};
      end
      @(negedge clk_i);
      if (rvalid_i && rready_o) begin
        beat++;
        holding = 1'b0;
      end else begin
        holding = rvalid_i;
      end
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for read data beats to drain");
    end
    @(posedge clk_i);
    rvalid_i <= 1'b0;
  endtask

  task automatic collect_reply(input logic [7:0] src, input int base);
    int k;
    int waited;
    mem_bridge_pkg::wh_flit_u exp;
    k = 0;
    waited = 0;
    while (k < 5) begin
      @(posedge clk_i);
      reply_ready <= coin_flip();
      @(negedge clk_i);
      if (wh_link_o.valid && reply_ready) begin
        if (k == 0) begin
          exp.header = '{dest_cord: src, len: 4'd4, default: '0};
        end else begin
          exp.data = golden_q[base+2+k];
        end
        check_flit("wh_link_o.data", wire_flit(wh_link_o.data), exp);
        k++;
      end
      waited++;
      if (waited > timeout_c) stop_on_error("timeout waiting for the read reply flits");
    end
    @(posedge clk_i);
    reply_ready <= 1'b0;
  endtask

  task automatic run_txn(input int t);
    int base;
    logic is_write;
    logic [7:0] src;
    logic [27:0] addr;
    mem_bridge_pkg::wh_flit_u hdr;
    mem_bridge_pkg::axi_aw_s exp;
    base     = t * txn_words_c;
    is_write = golden_q[base][0];
    src      = golden_q[base+1][7:0];
    addr     = golden_q[base+2][27:0];
    hdr.header = '{dest_cord: 8'h00, len: is_write ? 4'd5 : 4'd1, cid: 2'd0,
                   src_cord: src, write_not_read: is_write, padding: 9'd0};
    exp = '{id: 4'd0, addr: remap_addr(src, addr), len: 8'd3, size: 3'd2, burst: 2'b01};
    if (is_write) begin
      fork
        send_packet(hdr, addr, base, 1'b1);
        serve_write(exp, base);
      join
    end else begin
      fork
        send_packet(hdr, addr, base, 1'b0);
        serve_read(exp, base);
        collect_reply(src, base);
      join
    end
  endtask

  initial begin
    seed        = 15;
    rst_n_i     = 1'b0;
    in_valid    = 1'b0;
    in_flit     = '0;
    reply_ready = 1'b0;
    awready_i   = 1'b0;
    wready_i    = 1'b0;
    b_i         = '0;
    bvalid_i    = 1'b0;
    arready_i   = 1'b0;
    r_i         = '0;
    rvalid_i    = 1'b0;
    $readmemh("testbench/mem_bridge_golden.txt", golden_q);
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    check_reset_sequence();
    for (int t = 0; t < num_txn_c; t++) begin
      run_txn(t);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule
